// File: Makefile
TOOL       := verilator
TOP        := tb_fetch_frontend
FILELIST   := fetch_frontend.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench printed the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Width of one instruction address
`define XLEN 32

// PC bits [BP_INDEX_WIDTH+1:2] index both predictor tables
`define BP_INDEX_WIDTH 6

// Fetch starts here after reset
`define PC_RESET 32'h0000_0000

// One 32-bit instruction per fetch
`define PC_STEP 32'd4

`endif

// File: common/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    import fetch_pkg::*;

    // Two-bit saturating counter, upper bit set means taken
    typedef logic [1:0] pht_cnt_t;

    // PC bits above the table index
    typedef logic [`XLEN-`BP_INDEX_WIDTH-3:0] btb_tag_t;

    // One target buffer entry
    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        addr_t    target;
    } btb_entry_t;

    // Weakly not taken
    localparam pht_cnt_t PHT_RESET = 2'd1;

    // Empty entry
    localparam btb_entry_t BTB_RESET = '{
        valid:  1'b0,
        tag:    '0,
        target: '0
    };

endpackage

// File: common/fetch_pkg.sv
`include "bp_consts.svh"

package fetch_pkg;

    // One instruction address
    typedef logic [`XLEN-1:0] addr_t;

    // Kind of a resolved control transfer
    typedef enum logic [1:0] {
        BR_NONE = 2'b00,
        BR_COND = 2'b01,  // conditional branch
        BR_JAL  = 2'b10,  // direct jump, target known at fetch time
        BR_JALR = 2'b11   // indirect jump, never predicted
    } br_kind_t;

endpackage

// File: fetch_frontend.f
+incdir+common
common/fetch_pkg.sv
common/bp_pkg.sv
predictor/indexed_table.sv
predictor/branch_predictor.sv
hw/branch_resolve.sv
hw/pc_gen.sv
hw/fetch_frontend.sv
tb/clk_gen.sv
tb/tb_fetch_frontend.sv

// File: hw/branch_resolve.sv
`timescale 1ns/10ps

`include "bp_consts.svh"

module branch_resolve
    import fetch_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     res_vld_i,
    input  br_kind_t res_kind_i,
    input  addr_t    res_pc_i,
    input  addr_t    res_target_i,
    input  logic     res_taken_i,
    input  logic     res_pred_i,
    output logic     mispredict_o,
    output addr_t    recover_pc_o,
    output logic     update_en_o,
    output addr_t    upd_pc_o,
    output addr_t    upd_target_o,
    output logic     upd_taken_o
);

    br_kind_t slot_kind_q;
    logic     slot_taken_q;
    logic     slot_pred_q;
    addr_t    slot_pc_q;
    addr_t    slot_target_q;

    // Empty cycles become a BR_NONE slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_kind_q  <= BR_NONE;
            slot_taken_q <= 1'b0;
            slot_pred_q  <= 1'b0;
        end else begin
            slot_kind_q  <= res_vld_i ? res_kind_i : BR_NONE;
            slot_taken_q <= res_vld_i & res_taken_i;
            slot_pred_q  <= res_vld_i & res_pred_i;
        end
    end

    // Branch addresses, loaded with each valid resolve
    always_ff @(posedge clk_i) begin
        if (res_vld_i) begin
            slot_pc_q     <= res_pc_i;
            slot_target_q <= res_target_i;
        end
    end

    always_comb begin
        case (slot_kind_q)
            BR_COND, BR_JAL: mispredict_o = slot_pred_q ^ slot_taken_q;
            // Indirect targets are never predicted
            BR_JALR:         mispredict_o = 1'b1;
            default:         mispredict_o = 1'b0;
        endcase
    end

    assign recover_pc_o = slot_taken_q ? slot_target_q : slot_pc_q + `PC_STEP;

    // Only direct transfers train the tables
    assign update_en_o  = (slot_kind_q == BR_COND) || (slot_kind_q == BR_JAL);
    assign upd_pc_o     = slot_pc_q;
    assign upd_target_o = slot_target_q;
    assign upd_taken_o  = slot_taken_q;

endmodule

// File: hw/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend
    import fetch_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     stall_i,
    input  logic     res_vld_i,
    input  br_kind_t res_kind_i,
    input  addr_t    res_pc_i,
    input  addr_t    res_target_i,
    input  logic     res_taken_i,
    input  logic     res_pred_i,
    output addr_t    pc_o,
    output logic     pred_taken_o,
    output logic     btb_hit_o,
    output logic     flush_o
);

    addr_t fetch_pc;
    logic  pred_taken;
    addr_t pred_target;
    logic  mispredict;
    addr_t recover_pc;
    logic  update_en;
    addr_t upd_pc;
    addr_t upd_target;
    logic  upd_taken;

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .stall_i       (stall_i),
        .mispredict_i  (mispredict),
        .recover_pc_i  (recover_pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .pc_o          (fetch_pc)
    );

    // Looked up with the current PC in the same cycle
    branch_predictor u_predictor (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_pc_i    (fetch_pc),
        .update_en_i   (update_en),
        .upd_pc_i      (upd_pc),
        .upd_target_i  (upd_target),
        .upd_taken_i   (upd_taken),
        .pred_taken_o  (pred_taken),
        .btb_hit_o     (btb_hit_o),
        .pred_target_o (pred_target)
    );

    branch_resolve u_resolve (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .res_vld_i    (res_vld_i),
        .res_kind_i   (res_kind_i),
        .res_pc_i     (res_pc_i),
        .res_target_i (res_target_i),
        .res_taken_i  (res_taken_i),
        .res_pred_i   (res_pred_i),
        .mispredict_o (mispredict),
        .recover_pc_o (recover_pc),
        .update_en_o  (update_en),
        .upd_pc_o     (upd_pc),
        .upd_target_o (upd_target),
        .upd_taken_o  (upd_taken)
    );

    assign pc_o         = fetch_pc;
    assign pred_taken_o = pred_taken;
    assign flush_o      = mispredict;

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/10ps

`include "bp_consts.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  stall_i,
    input  logic  mispredict_i,
    input  addr_t recover_pc_i,
    input  logic  pred_taken_i,
    input  addr_t pred_target_i,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_seq;
    addr_t pc_next;
    logic  pc_load;

    assign pc_seq = pc_q + `PC_STEP;

    // Recovery first, then prediction, then fall through
    always_comb begin
        if (mispredict_i) begin
            pc_next = recover_pc_i;
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;
        end else begin
            pc_next = pc_seq;
        end
    end

    // A flush must land even while stalled
    assign pc_load = mispredict_i | ~stall_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= `PC_RESET;
        end else if (pc_load) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: predictor/branch_predictor.sv
`timescale 1ns/10ps

`include "bp_consts.svh"

module branch_predictor
    import fetch_pkg::*;
    import bp_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  addr_t fetch_pc_i,
    input  logic  update_en_i,
    input  addr_t upd_pc_i,
    input  addr_t upd_target_i,
    input  logic  upd_taken_i,
    output logic  pred_taken_o,
    output logic  btb_hit_o,
    output addr_t pred_target_o
);

    localparam int unsigned IDX_W = `BP_INDEX_WIDTH;
    localparam int unsigned DEPTH = 1 << IDX_W;

    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] upd_idx;
    btb_tag_t         fetch_tag;
    btb_tag_t         upd_tag;
    pht_cnt_t         fetch_cnt;
    pht_cnt_t         upd_cnt;
    pht_cnt_t         upd_cnt_next;
    btb_entry_t       fetch_entry;
    btb_entry_t       upd_entry;
    logic             btb_wr_en;

    // Byte offset bits are dropped, index sits right above them
    assign fetch_idx = fetch_pc_i[IDX_W+1:2];
    assign fetch_tag = fetch_pc_i[`XLEN-1:IDX_W+2];
    assign upd_idx   = upd_pc_i[IDX_W+1:2];
    assign upd_tag   = upd_pc_i[`XLEN-1:IDX_W+2];

    // Port a serves fetch, port b reads the counter being updated
    indexed_table #(
        .entry_t (pht_cnt_t),
        .DEPTH   (DEPTH),
        .RST_VAL (PHT_RESET)
    ) u_pht (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_idx_a_i  (fetch_idx),
        .rd_data_a_o (fetch_cnt),
        .rd_idx_b_i  (upd_idx),
        .rd_data_b_o (upd_cnt),
        .wr_en_i     (update_en_i),
        .wr_idx_i    (upd_idx),
        .wr_data_i   (upd_cnt_next)
    );

    // Target buffer only needs the fetch read
    indexed_table #(
        .entry_t (btb_entry_t),
        .DEPTH   (DEPTH),
        .RST_VAL (BTB_RESET)
    ) u_btb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd_idx_a_i  (fetch_idx),
        .rd_data_a_o (fetch_entry),
        .rd_idx_b_i  (upd_idx),
        .rd_data_b_o (),
        .wr_en_i     (btb_wr_en),
        .wr_idx_i    (upd_idx),
        .wr_data_i   (upd_entry)
    );

    // Saturating step toward the resolved direction
    always_comb begin
        upd_cnt_next = upd_cnt;
        if (upd_taken_i) begin
            if (upd_cnt != 2'd3) begin
                upd_cnt_next = upd_cnt + 2'd1;
            end
        end else if (upd_cnt != 2'd0) begin
            upd_cnt_next = upd_cnt - 2'd1;
        end
    end

    // Taken branches allocate or refresh their entry
    assign btb_wr_en = update_en_i & upd_taken_i;
    assign upd_entry = '{valid: 1'b1, tag: upd_tag, target: upd_target_i};

    assign btb_hit_o     = fetch_entry.valid && (fetch_entry.tag == fetch_tag);
    assign pred_taken_o  = btb_hit_o & fetch_cnt[1];
    assign pred_target_o = fetch_entry.target;

endmodule

// File: predictor/indexed_table.sv
`timescale 1ns/10ps

`include "bp_consts.svh"

module indexed_table #(
    parameter type          entry_t = logic [1:0],
    parameter int unsigned  DEPTH   = 1 << `BP_INDEX_WIDTH,
    parameter entry_t       RST_VAL = '0,
    localparam int unsigned IDX_W   = $clog2(DEPTH)
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [IDX_W-1:0] rd_idx_a_i,
    output entry_t           rd_data_a_o,
    input  logic [IDX_W-1:0] rd_idx_b_i,
    output entry_t           rd_data_b_o,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  entry_t           wr_data_i
);

    entry_t mem_q [DEPTH];

    // Every entry returns to the default on reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RST_VAL;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

    // Reads see the old contents during a write cycle
    assign rd_data_a_o = mem_q[rd_idx_a_i];
    assign rd_data_b_o = mem_q[rd_idx_b_i];

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 2
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release lands 1 ns after an edge, away from the sampling point
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

// File: tb/fetch_vectors.txt
// beh stall vld kind res_pc res_target taken pred exp_pc exp_pred exp_hit exp_flush
// kind 0 none 1 cond 2 jal 3 jalr, expected values hold after the edge sampling the line
1 0 0 0 0 0 0 0 8 0 0 0
1 0 0 0 0 0 0 0 c 0 0 0
1 1 0 0 0 0 0 0 c 0 0 0
1 1 0 0 0 0 0 0 c 0 0 0
1 0 0 0 0 0 0 0 10 0 0 0
1 0 0 0 0 0 0 0 14 0 0 0
2 0 1 1 10 80 1 0 18 0 0 1
2 0 0 0 0 0 0 0 80 0 0 0
2 0 1 1 10 80 1 1 84 0 0 0
2 0 0 0 0 0 0 0 88 0 0 0
2 0 1 3 200 10 1 0 8c 0 0 1
2 0 0 0 0 0 0 0 10 1 1 0
2 0 0 0 0 0 0 0 80 0 0 0
2 0 0 0 0 0 0 0 84 0 0 0
4 0 1 3 10 300 1 1 88 0 0 1
4 0 0 0 0 0 0 0 300 0 0 0
4 0 1 3 400 10 1 0 304 0 0 1
4 0 0 0 0 0 0 0 10 1 1 0
4 0 0 0 0 0 0 0 80 0 0 0
3 0 1 1 10 80 0 1 84 0 0 1
3 0 0 0 0 0 0 0 14 0 0 0
3 0 1 1 10 80 0 1 18 0 0 1
3 0 0 0 0 0 0 0 14 0 0 0
3 0 1 3 500 10 1 0 18 0 0 1
3 0 0 0 0 0 0 0 10 0 1 0
3 0 0 0 0 0 0 0 14 0 0 0
5 1 1 1 10 80 1 0 14 0 0 1
5 1 0 0 0 0 0 0 80 0 0 0
5 1 0 0 0 0 0 0 80 0 0 0
5 0 0 0 0 0 0 0 84 0 0 0
6 0 1 3 600 110 1 0 88 0 0 1
6 0 0 0 0 0 0 0 110 0 0 0
6 0 1 3 700 10 1 0 114 0 0 1
6 0 0 0 0 0 0 0 10 1 1 0
6 0 0 0 0 0 0 0 80 0 0 0

// File: tb/tb_fetch_frontend.sv
`timescale 1ns/10ps

`include "bp_consts.svh"

module tb_fetch_frontend
    import fetch_pkg::*;
();

    // Columns of one vector line
    localparam int COLS        = 12;
    localparam int MAX_VEC     = 64;
    localparam int DRIVE_DELAY = 1;
    localparam int CHECK_DELAY = 2;

    localparam logic [31:0] END_MARK = 32'hFFFF_FFFF;

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     res_vld;
    br_kind_t res_kind;
    addr_t    res_pc;
    addr_t    res_target;
    logic     res_taken;
    logic     res_pred;
    addr_t    pc;
    logic     pred_taken;
    logic     btb_hit;
    logic     flush;

    logic [31:0] vec_mem [MAX_VEC*COLS];
    int          n_vec;
    int          err_cnt;
    int          cycle_cnt = 0;
    int          cycle_limit;

    clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    fetch_frontend uut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .stall_i      (stall),
        .res_vld_i    (res_vld),
        .res_kind_i   (res_kind),
        .res_pc_i     (res_pc),
        .res_target_i (res_target),
        .res_taken_i  (res_taken),
        .res_pred_i   (res_pred),
        .pc_o         (pc),
        .pred_taken_o (pred_taken),
        .btb_hit_o    (btb_hit),
        .flush_o      (flush)
    );

    function automatic string behavior_name(input logic [31:0] id);
        case (id)
            32'd1:   return "pc_step_and_stall";
            32'd2:   return "taken_cond_training";
            32'd3:   return "not_taken_recovery";
            32'd4:   return "jalr_flush";
            32'd5:   return "flush_over_stall";
            32'd6:   return "tag_alias";
            default: return "unknown";
        endcase
    endfunction

    task automatic drive_idle();
        stall      = 1'b0;
        res_vld    = 1'b0;
        res_kind   = BR_NONE;
        res_pc     = '0;
        res_target = '0;
        res_taken  = 1'b0;
        res_pred   = 1'b0;
    endtask

    task automatic drive_vector(input int idx);
        int base;
        base       = idx * COLS;
        stall      = vec_mem[base+1][0];
        res_vld    = vec_mem[base+2][0];
        res_kind   = br_kind_t'(vec_mem[base+3][1:0]);
        res_pc     = vec_mem[base+4];
        res_target = vec_mem[base+5];
        res_taken  = vec_mem[base+6][0];
        res_pred   = vec_mem[base+7][0];
    endtask

    // Expected values hold for the state after the edge that sampled the line
    task automatic check_vector(input int idx);
        int    base;
        string name;
        base = idx * COLS;
        name = behavior_name(vec_mem[base]);
        assert (pc === vec_mem[base+8]) else begin
            $display("[FAIL] %s line %0d: pc_o expected %h, actual %h",
                     name, idx, vec_mem[base+8], pc);
            err_cnt++;
        end
        assert (pred_taken === vec_mem[base+9][0]) else begin
            $display("[FAIL] %s line %0d: pred_taken_o expected %b, actual %b",
                     name, idx, vec_mem[base+9][0], pred_taken);
            err_cnt++;
        end
        assert (btb_hit === vec_mem[base+10][0]) else begin
            $display("[FAIL] %s line %0d: btb_hit_o expected %b, actual %b",
                     name, idx, vec_mem[base+10][0], btb_hit);
            err_cnt++;
        end
        assert (flush === vec_mem[base+11][0]) else begin
            $display("[FAIL] %s line %0d: flush_o expected %b, actual %b",
                     name, idx, vec_mem[base+11][0], flush);
            err_cnt++;
        end
    endtask

    task automatic check_reset_state();
        assert (pc === `PC_RESET) else begin
            $display("[FAIL] reset: pc_o expected %h, actual %h", `PC_RESET, pc);
            err_cnt++;
        end
        assert (pred_taken === 1'b0 && btb_hit === 1'b0 && flush === 1'b0) else begin
            $display("[FAIL] reset: pred/hit/flush expected 000, actual %b%b%b",
                     pred_taken, btb_hit, flush);
            err_cnt++;
        end
    endtask

    initial begin
        err_cnt = 0;
        n_vec   = 0;
        drive_idle();
        for (int i = 0; i < MAX_VEC * COLS; i++) begin
            vec_mem[i] = END_MARK;
        end
        $readmemh("tb/fetch_vectors.txt", vec_mem);
        // Untouched entries keep the end mark
        while (n_vec < MAX_VEC && vec_mem[n_vec*COLS] != END_MARK) begin
            n_vec++;
        end
        cycle_limit = n_vec + 20;
        if (n_vec == 0) begin
            $display("No vectors could be loaded from tb/fetch_vectors.txt");
            err_cnt++;
        end

        wait (rst_n === 1'b1);
        #1;
        check_reset_state();

        // Line i is driven while line i-1 is checked
        for (int i = 0; i <= n_vec; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (i < n_vec) begin
                drive_vector(i);
            end else begin
                drive_idle();
            end
            #(CHECK_DELAY);
            if (i > 0) begin
                check_vector(i - 1);
            end
        end

        $display("Run complete: %0d vectors, %0d errors", n_vec, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            err_cnt++;
            $display("Run stopped: %0d vectors, %0d errors", n_vec, err_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule
